// ==== common/md_bus_pkg.sv ====
// ----------------------------
// Bus fabric definitions
// Widths, FSM encodings and fixed addresses shared by the main and sound buses
// ----------------------------
package md_bus_pkg;

	// ----------------------------
	// Bus widths
	// ----------------------------
	// Main bus word address from byte address bits 23:1
	typedef logic [22:0] maddr_t;
	typedef logic [15:0] mdata_t;
	// Sound bus byte address in a 32 KB space
	typedef logic [14:0] zaddr_t;
	typedef logic [7:0] zdata_t;
	// Bank register forms main bus byte address bits 23:15
	typedef logic [8:0] bank_t;

	// ----------------------------
	// State machines
	// ----------------------------
	typedef enum logic [2:0] {
		MB_IDLE,
		MB_SELECT,
		MB_RAM_READ,
		MB_ROM_READ,
		MB_ZBUS_PRE,
		MB_ZBUS_READ,
		MB_FINISH
	} mstate_t;

	typedef enum logic [1:0] {
		SRC_NONE,
		SRC_CPU,
		SRC_Z80
	} msrc_t;

	typedef enum logic [1:0] {
		ZB_IDLE,
		ZB_READ,
		ZB_FINISH
	} zstate_t;

	typedef enum logic {
		ZSRC_MBUS,
		ZSRC_Z80
	} zsrc_t;

	// ----------------------------
	// Fixed values and pages
	// ----------------------------
	// Returned by absent sound bus devices
	localparam zdata_t OPEN_BYTE = 8'hFF;
	// Control register pages A11100 and A11200
	localparam logic [3:0] CTRL_BUSREQ_PAGE = 4'd1;
	localparam logic [3:0] CTRL_RESET_PAGE = 4'd2;
	// Bank register sits at 6000-60FF of the sound bus
	localparam logic [6:0] ZBUS_BANK_PAGE = 7'h60;

endpackage

// ==== src/open_bus_noise.sv ====
// ----------------------------
// Open bus noise
// Pseudo-random data for reads that hit nothing
// ----------------------------
`timescale 1ns/1ps

module open_bus_noise import md_bus_pkg::*; (
	input  logic   MCLK,
	input  logic   reset,
	output mdata_t noise
);

	logic [16:0] lfsr;

	// x^17 + x^14 + 1, one new bit per clock
	always_ff @(posedge MCLK) begin
		if (reset) begin
			lfsr <= 17'h1ACE1;
			noise <= '0;
		end else begin
			lfsr <= {lfsr[0] ^ lfsr[3], lfsr[16:1]};
			noise <= {noise[14:0], lfsr[0]};
		end
	end

endmodule

// ==== src/work_ram.sv ====
// ----------------------------
// Main work RAM
// Word wide with a write enable per byte lane
// ----------------------------
`timescale 1ns/1ps

module work_ram import md_bus_pkg::*; #(
	parameter int WRAM_AW = 15
) (
	input  logic               MCLK,
	input  logic [WRAM_AW-1:0] addr,
	input  mdata_t             wdata,
	input  logic               we_u,
	input  logic               we_l,
	output mdata_t             q
);

	logic [1:0] lane_we;

	// Lane 1 is the upper byte
	assign lane_we = {we_u, we_l};

	for (genvar i = 0; i < 2; i++) begin : g_lane
		logic [7:0] mem [2**WRAM_AW];

		always_ff @(posedge MCLK) begin
			if (lane_we[i])
				mem[addr] <= wdata[8*i +: 8];
			q[8*i +: 8] <= mem[addr];
		end
	end

endmodule

// ==== src/z80_bridge.sv ====
// ----------------------------
// Sound CPU bridge
// Sends sound CPU cycles to the sound bus or through the bank window
// to the main bus and holds the CPU in wait until the answer is back
// ----------------------------
`timescale 1ns/1ps

module z80_bridge import md_bus_pkg::*; (
	input  logic        MCLK,
	input  logic        reset,
	input  logic        z80_mreq_n,
	input  logic        z80_rd_n,
	input  logic        z80_wr_n,
	input  logic [15:0] z80_addr,
	input  zdata_t      z80_wdata,
	output zdata_t      z80_rdata,
	output logic        z80_wait_n,
	input  bank_t       bank,
	// To the main bus
	output logic        zm_req,
	output maddr_t      zm_addr,
	output logic        zm_rnw,
	output logic        zm_uds_n,
	output logic        zm_lds_n,
	output mdata_t      zm_wdata,
	input  mdata_t      zm_rdata,
	input  logic        zm_ack,
	// To the sound bus
	output logic        zz_req,
	output zaddr_t      zz_addr,
	output logic        zz_we,
	output zdata_t      zz_wdata,
	input  zdata_t      zz_rdata,
	input  logic        zz_ack
);

	logic z80_io;
	logic is_zbus;
	logic start;
	logic done;

	assign z80_io = ~z80_mreq_n & (~z80_rd_n | ~z80_wr_n);
	// 0000-7EFF stays on the sound bus
	assign is_zbus = ~z80_addr[15] & ~&z80_addr[14:8];
	// Wait for both acks to drop so a stale ack is never taken
	assign start = z80_io & ~done & ~zm_req & ~zz_req & ~zm_ack & ~zz_ack;
	assign z80_wait_n = ~(z80_io & ~done);

	always_ff @(posedge MCLK) begin
		if (reset) begin
			zm_req <= 1'b0;
			zz_req <= 1'b0;
			done <= 1'b0;
		end else begin
			if (!z80_io)
				done <= 1'b0;
			if (zm_req && zm_ack) begin
				zm_req <= 1'b0;
				done <= 1'b1;
			end
			if (zz_req && zz_ack) begin
				zz_req <= 1'b0;
				done <= 1'b1;
			end
			if (start) begin
				zz_req <= is_zbus;
				zm_req <= ~is_zbus;
			end
		end
	end

	always_ff @(posedge MCLK) begin
		if (start) begin
			zz_addr <= z80_addr[14:0];
			zz_we <= ~z80_wr_n;
			zz_wdata <= z80_wdata;
			// 7F00-7FFF falls on C000xx, which nothing decodes
			zm_addr <= z80_addr[15] ? {bank, z80_addr[14:1]} : {16'hC000, z80_addr[7:1]};
			zm_rnw <= z80_wr_n;
			zm_uds_n <= z80_addr[0];
			zm_lds_n <= ~z80_addr[0];
			zm_wdata <= {z80_wdata, z80_wdata};
		end
		if (zz_req && zz_ack)
			z80_rdata <= zz_rdata;
		if (zm_req && zm_ack)
			z80_rdata <= zm_uds_n ? zm_rdata[7:0] : zm_rdata[15:8];
	end

endmodule

// ==== src/mbus/mbus_ctrl.sv ====
// ----------------------------
// Main bus controller
// Arbitrates the main CPU and the sound CPU bridge, decodes the address map,
// holds the sound CPU control register and drives the cartridge ROM port
// ----------------------------
`timescale 1ns/1ps

module mbus_ctrl import md_bus_pkg::*; #(
	parameter int WRAM_AW = 15
) (
	input  logic               MCLK,
	input  logic               reset,
	// Main CPU
	input  logic               cpu_as_n,
	input  logic               cpu_uds_n,
	input  logic               cpu_lds_n,
	input  logic               cpu_rnw,
	input  maddr_t             cpu_addr,
	input  mdata_t             cpu_wdata,
	output mdata_t             cpu_rdata,
	output logic               cpu_dtack_n,
	// Sound CPU bridge
	input  logic               zm_req,
	input  maddr_t             zm_addr,
	input  logic               zm_rnw,
	input  logic               zm_uds_n,
	input  logic               zm_lds_n,
	input  mdata_t             zm_wdata,
	output mdata_t             zm_rdata,
	output logic               zm_ack,
	// Sound bus
	output logic               mz_req,
	output zaddr_t             mz_addr,
	output logic               mz_we,
	output zdata_t             mz_wdata,
	input  zdata_t             mz_rdata,
	input  logic               mz_ack,
	// Cartridge ROM
	output maddr_t             rom_addr,
	output logic               rom_req,
	input  logic               rom_ack,
	input  mdata_t             rom_data,
	input  maddr_t             rom_size,
	input  mdata_t             noise,
	// Work RAM
	output logic [WRAM_AW-1:0] wram_addr,
	output mdata_t             wram_wdata,
	output logic               wram_we_u,
	output logic               wram_we_l,
	input  mdata_t             wram_q,
	// Sound CPU control
	output logic               z80_busrq_n,
	output logic               z80_reset_n
);

	mstate_t mstate;
	msrc_t msrc;
	maddr_t mbus_a;
	mdata_t mbus_do;
	mdata_t rd_data;
	logic mbus_rnw;
	logic mbus_uds_n;
	logic mbus_lds_n;
	logic ram_sel;

	// ----------------------------
	// Address decode
	// ----------------------------
	logic [3:0] ctrl_page;
	logic is_rom_area;
	logic is_zbus;
	logic is_ctrl;
	logic is_wram;
	logic ctrl_bit;

	assign ctrl_page = mbus_a[10:7];
	// 000000-9FFFFF
	assign is_rom_area = mbus_a[22:19] < 4'hA;
	// A00000-A0FFFF
	assign is_zbus = mbus_a[22:15] == 8'hA0;
	assign is_ctrl = mbus_a[22:11] == 12'hA11 && mbus_a[6:0] == '0 &&
		(ctrl_page == CTRL_BUSREQ_PAGE || ctrl_page == CTRL_RESET_PAGE);
	// E00000-FFFFFF
	assign is_wram = &mbus_a[22:20];
	// Reads show the written sense of the bit
	assign ctrl_bit = (ctrl_page == CTRL_BUSREQ_PAGE) ? ~z80_busrq_n : z80_reset_n;

	// Strobes for a sound bus cycle; the CPU may assert its strobes late on writes
	logic pre_go;
	logic pre_uds_n;
	logic pre_lds_n;

	assign pre_go = msrc != SRC_CPU || cpu_as_n || !cpu_uds_n || !cpu_lds_n;
	assign pre_uds_n = (msrc == SRC_CPU) ? cpu_uds_n : mbus_uds_n;
	assign pre_lds_n = (msrc == SRC_CPU) ? cpu_lds_n : mbus_lds_n;

	assign rom_addr = mbus_a;
	assign wram_addr = mbus_a[WRAM_AW-1:0];
	assign wram_wdata = mbus_do;
	assign wram_we_u = ram_sel & ~mbus_rnw & ~mbus_uds_n;
	assign wram_we_l = ram_sel & ~mbus_rnw & ~mbus_lds_n;

	always_ff @(posedge MCLK) begin
		if (reset) begin
			mstate <= MB_IDLE;
			msrc <= SRC_NONE;
			cpu_dtack_n <= 1'b1;
			zm_ack <= 1'b0;
			mz_req <= 1'b0;
			rom_req <= 1'b0;
			ram_sel <= 1'b0;
			mbus_rnw <= 1'b1;
			z80_busrq_n <= 1'b1;
			z80_reset_n <= 1'b0;
		end else begin
			if (cpu_as_n)
				cpu_dtack_n <= 1'b1;
			if (!zm_req)
				zm_ack <= 1'b0;

			case (mstate)
				MB_IDLE: begin
					ram_sel <= 1'b0;
					if (!cpu_as_n && cpu_dtack_n) begin
						// Main CPU wins a tie
						msrc <= SRC_CPU;
						mbus_a <= cpu_addr;
						mbus_do <= cpu_wdata;
						mbus_rnw <= cpu_rnw;
						mbus_uds_n <= cpu_uds_n;
						mbus_lds_n <= cpu_lds_n;
						rd_data <= noise;
						mstate <= MB_SELECT;
					end else if (zm_req && !zm_ack && cpu_dtack_n) begin
						// Bridge waits until the last CPU cycle has closed
						msrc <= SRC_Z80;
						mbus_a <= zm_addr;
						mbus_do <= zm_wdata;
						mbus_rnw <= zm_rnw;
						mbus_uds_n <= zm_uds_n;
						mbus_lds_n <= zm_lds_n;
						rd_data <= '1;
						mstate <= MB_SELECT;
					end
				end

				MB_SELECT: begin
					// Unmapped addresses keep the preset data
					mstate <= MB_FINISH;
					if (is_rom_area) begin
						if (mbus_a < rom_size) begin
							rom_req <= ~rom_ack;
							mstate <= MB_ROM_READ;
						end else begin
							rd_data <= '0;
						end
					end else if (is_zbus) begin
						mstate <= MB_ZBUS_PRE;
					end else if (is_ctrl) begin
						rd_data <= {noise[15:9], ctrl_bit, noise[7:0]};
						if (!mbus_rnw && !mbus_uds_n) begin
							if (ctrl_page == CTRL_BUSREQ_PAGE)
								z80_busrq_n <= ~mbus_do[8];
							else
								z80_reset_n <= mbus_do[8];
						end
					end else if (is_wram) begin
						ram_sel <= 1'b1;
						mstate <= MB_RAM_READ;
					end
				end

				MB_RAM_READ: begin
					ram_sel <= 1'b0;
					rd_data <= wram_q;
					mstate <= MB_FINISH;
				end

				MB_ROM_READ: begin
					if (rom_req == rom_ack) begin
						rd_data <= rom_data;
						mstate <= MB_FINISH;
					end
				end

				MB_ZBUS_PRE: begin
					if (pre_go) begin
						mbus_uds_n <= pre_uds_n;
						mbus_lds_n <= pre_lds_n;
						// Odd byte address when the upper strobe is off
						mz_addr <= {mbus_a[13:0], pre_uds_n};
						mz_we <= ~mbus_rnw;
						mz_wdata <= pre_uds_n ? mbus_do[7:0] : mbus_do[15:8];
						mz_req <= 1'b1;
						mstate <= MB_ZBUS_READ;
					end
				end

				MB_ZBUS_READ: begin
					if (mz_ack) begin
						mz_req <= 1'b0;
						rd_data <= {mz_rdata, mz_rdata};
						mstate <= MB_FINISH;
					end
				end

				MB_FINISH: begin
					if (msrc == SRC_CPU) begin
						if (!cpu_as_n) begin
							cpu_rdata <= rd_data;
							cpu_dtack_n <= 1'b0;
						end
						// Hold until the cycle ends or the write strobes show up
						if (cpu_as_n || (!mbus_rnw && (!cpu_uds_n || !cpu_lds_n)))
							mstate <= MB_IDLE;
					end else begin
						zm_rdata <= rd_data;
						zm_ack <= 1'b1;
						mstate <= MB_IDLE;
					end
				end

				default: mstate <= MB_IDLE;
			endcase
		end
	end

	// DTACK is only low while the main CPU still owns the bus
	a_dtack_owner: assert property (@(posedge MCLK) disable iff (reset)
		!cpu_dtack_n |-> msrc == SRC_CPU);

endmodule

// ==== src/zbus/zbus_ctrl.sv ====
// ----------------------------
// Sound bus controller
// Shares the sound RAM between the main bus and the sound CPU
// and holds the bank register for the 8000-FFFF window
// ----------------------------
`timescale 1ns/1ps

module zbus_ctrl import md_bus_pkg::*; #(
	parameter int ZRAM_AW = 13
) (
	input  logic   MCLK,
	input  logic   reset,
	// From the main bus
	input  logic   mz_req,
	input  zaddr_t mz_addr,
	input  logic   mz_we,
	input  zdata_t mz_wdata,
	output zdata_t mz_rdata,
	output logic   mz_ack,
	// From the sound CPU bridge
	input  logic   zz_req,
	input  zaddr_t zz_addr,
	input  logic   zz_we,
	input  zdata_t zz_wdata,
	output zdata_t zz_rdata,
	output logic   zz_ack,
	input  logic   z80_busrq_n,
	input  logic   z80_reset_n,
	output bank_t  bank
);

	zstate_t zstate;
	zsrc_t zsrc;
	zaddr_t zb_a;
	zdata_t zb_do;
	zdata_t zb_di;
	logic zb_we;
	logic zbus_free;
	logic zram_sel;
	logic zram_we;
	zdata_t zram_q;
	zdata_t zram [2**ZRAM_AW];

	// Main bus only gets through with the bus granted and the CPU running
	assign zbus_free = ~z80_busrq_n & z80_reset_n;

	// ----------------------------
	// Sound RAM mirrored over 0000-3FFF
	// ----------------------------
	assign zram_sel = ~zb_a[14];
	assign zram_we = zb_we & zram_sel;
	assign zb_di = zram_sel ? zram_q : OPEN_BYTE;

	always_ff @(posedge MCLK) begin
		if (zram_we)
			zram[zb_a[ZRAM_AW-1:0]] <= zb_do;
		zram_q <= zram[zb_a[ZRAM_AW-1:0]];
	end

	// Bank bits arrive one per write with the LSB first
	always_ff @(posedge MCLK) begin
		if (reset)
			bank <= '0;
		else if (zb_we && zb_a[14:8] == ZBUS_BANK_PAGE)
			bank <= {zb_do[0], bank[8:1]};
	end

	always_ff @(posedge MCLK) begin
		if (reset) begin
			zstate <= ZB_IDLE;
			zsrc <= ZSRC_MBUS;
			zb_we <= 1'b0;
			mz_ack <= 1'b0;
			zz_ack <= 1'b0;
		end else begin
			zb_we <= 1'b0;
			if (!mz_req)
				mz_ack <= 1'b0;
			if (!zz_req)
				zz_ack <= 1'b0;

			case (zstate)
				ZB_IDLE: begin
					if (mz_req && !mz_ack) begin
						zb_a <= mz_addr;
						zb_do <= mz_wdata;
						// Writes without the bus are dropped
						zb_we <= mz_we & zbus_free;
						zsrc <= ZSRC_MBUS;
						zstate <= ZB_READ;
					end else if (zz_req && !zz_ack) begin
						zb_a <= zz_addr;
						zb_do <= zz_wdata;
						zb_we <= zz_we;
						zsrc <= ZSRC_Z80;
						zstate <= ZB_READ;
					end
				end

				ZB_READ: zstate <= ZB_FINISH;

				ZB_FINISH: begin
					if (zsrc == ZSRC_MBUS) begin
						mz_rdata <= zbus_free ? zb_di : OPEN_BYTE;
						mz_ack <= 1'b1;
					end else begin
						zz_rdata <= zb_di;
						zz_ack <= 1'b1;
					end
					zstate <= ZB_IDLE;
				end

				default: zstate <= ZB_IDLE;
			endcase
		end
	end

	// The grant still holds on the edge where a main bus write lands in RAM
	a_no_ungranted_write: assert property (@(posedge MCLK) disable iff (reset)
		(zram_we && zsrc == ZSRC_MBUS) |-> (~z80_busrq_n & z80_reset_n));

endmodule

// ==== src/md_bus_top.sv ====
// ----------------------------
// Console bus fabric top
// Main bus, sound bus, work RAM and the sound CPU bridge
// ----------------------------
`timescale 1ns/1ps

module md_bus_top import md_bus_pkg::*; #(
	parameter int WRAM_AW = 15,
	parameter int ZRAM_AW = 13
) (
	input  logic        MCLK,
	input  logic        reset,
	// Main CPU
	input  logic        cpu_as_n,
	input  logic        cpu_uds_n,
	input  logic        cpu_lds_n,
	input  logic        cpu_rnw,
	input  maddr_t      cpu_addr,
	input  mdata_t      cpu_wdata,
	output mdata_t      cpu_rdata,
	output logic        cpu_dtack_n,
	// Sound CPU
	input  logic        z80_mreq_n,
	input  logic        z80_rd_n,
	input  logic        z80_wr_n,
	input  logic [15:0] z80_addr,
	input  zdata_t      z80_wdata,
	output zdata_t      z80_rdata,
	output logic        z80_wait_n,
	output logic        z80_busrq_n,
	output logic        z80_reset_n,
	// Cartridge ROM
	input  maddr_t      rom_size,
	output maddr_t      rom_addr,
	output logic        rom_req,
	input  logic        rom_ack,
	input  mdata_t      rom_data
);

	// Bridge to main bus
	logic zm_req;
	maddr_t zm_addr;
	logic zm_rnw;
	logic zm_uds_n;
	logic zm_lds_n;
	mdata_t zm_wdata;
	mdata_t zm_rdata;
	logic zm_ack;

	// Main bus to sound bus
	logic mz_req;
	zaddr_t mz_addr;
	logic mz_we;
	zdata_t mz_wdata;
	zdata_t mz_rdata;
	logic mz_ack;

	// Bridge to sound bus
	logic zz_req;
	zaddr_t zz_addr;
	logic zz_we;
	zdata_t zz_wdata;
	zdata_t zz_rdata;
	logic zz_ack;

	bank_t bank;
	mdata_t noise;
	logic [WRAM_AW-1:0] wram_addr;
	mdata_t wram_wdata;
	logic wram_we_u;
	logic wram_we_l;
	mdata_t wram_q;

	z80_bridge u_bridge (
		.MCLK(MCLK), .reset(reset),
		.z80_mreq_n(z80_mreq_n), .z80_rd_n(z80_rd_n), .z80_wr_n(z80_wr_n),
		.z80_addr(z80_addr), .z80_wdata(z80_wdata), .z80_rdata(z80_rdata),
		.z80_wait_n(z80_wait_n), .bank(bank),
		.zm_req(zm_req), .zm_addr(zm_addr), .zm_rnw(zm_rnw), .zm_uds_n(zm_uds_n),
		.zm_lds_n(zm_lds_n), .zm_wdata(zm_wdata), .zm_rdata(zm_rdata), .zm_ack(zm_ack),
		.zz_req(zz_req), .zz_addr(zz_addr), .zz_we(zz_we), .zz_wdata(zz_wdata),
		.zz_rdata(zz_rdata), .zz_ack(zz_ack)
	);

	mbus_ctrl #(.WRAM_AW(WRAM_AW)) u_mbus (
		.MCLK(MCLK), .reset(reset),
		.cpu_as_n(cpu_as_n), .cpu_uds_n(cpu_uds_n), .cpu_lds_n(cpu_lds_n),
		.cpu_rnw(cpu_rnw), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
		.cpu_rdata(cpu_rdata), .cpu_dtack_n(cpu_dtack_n),
		.zm_req(zm_req), .zm_addr(zm_addr), .zm_rnw(zm_rnw), .zm_uds_n(zm_uds_n),
		.zm_lds_n(zm_lds_n), .zm_wdata(zm_wdata), .zm_rdata(zm_rdata), .zm_ack(zm_ack),
		.mz_req(mz_req), .mz_addr(mz_addr), .mz_we(mz_we), .mz_wdata(mz_wdata),
		.mz_rdata(mz_rdata), .mz_ack(mz_ack),
		.rom_addr(rom_addr), .rom_req(rom_req), .rom_ack(rom_ack), .rom_data(rom_data),
		.rom_size(rom_size), .noise(noise),
		.wram_addr(wram_addr), .wram_wdata(wram_wdata), .wram_we_u(wram_we_u),
		.wram_we_l(wram_we_l), .wram_q(wram_q),
		.z80_busrq_n(z80_busrq_n), .z80_reset_n(z80_reset_n)
	);

	zbus_ctrl #(.ZRAM_AW(ZRAM_AW)) u_zbus (
		.MCLK(MCLK), .reset(reset),
		.mz_req(mz_req), .mz_addr(mz_addr), .mz_we(mz_we), .mz_wdata(mz_wdata),
		.mz_rdata(mz_rdata), .mz_ack(mz_ack),
		.zz_req(zz_req), .zz_addr(zz_addr), .zz_we(zz_we), .zz_wdata(zz_wdata),
		.zz_rdata(zz_rdata), .zz_ack(zz_ack),
		.z80_busrq_n(z80_busrq_n), .z80_reset_n(z80_reset_n), .bank(bank)
	);

	work_ram #(.WRAM_AW(WRAM_AW)) u_wram (
		.MCLK(MCLK), .addr(wram_addr), .wdata(wram_wdata),
		.we_u(wram_we_u), .we_l(wram_we_l), .q(wram_q)
	);

	open_bus_noise u_noise (
		.MCLK(MCLK), .reset(reset), .noise(noise)
	);

endmodule

// ==== bench/md_bus_tb.sv ====
// ----------------------------
// Bus fabric testbench
// Plays main CPU and sound CPU cycles from a vector file against the fabric,
// with a cartridge ROM model and a watchdog
// ----------------------------
`timescale 1ns/1ps

module md_bus_tb import md_bus_pkg::*;;

	localparam int MAX_VEC = 64;

	logic MCLK;
	logic reset;
	logic cpu_as_n;
	logic cpu_uds_n;
	logic cpu_lds_n;
	logic cpu_rnw;
	maddr_t cpu_addr;
	mdata_t cpu_wdata;
	mdata_t cpu_rdata;
	logic cpu_dtack_n;
	logic z80_mreq_n;
	logic z80_rd_n;
	logic z80_wr_n;
	logic [15:0] z80_addr;
	zdata_t z80_wdata;
	zdata_t z80_rdata;
	logic z80_wait_n;
	logic z80_busrq_n;
	logic z80_reset_n;
	maddr_t rom_size;
	maddr_t rom_addr;
	logic rom_req;
	logic rom_ack;
	mdata_t rom_data;

	// One vector per entry with fields as in the header of the data file
	logic [83:0] vec [MAX_VEC];
	int n_vec;
	int errors;
	int checks;
	logic loaded;

	md_bus_top UUT (
		.MCLK(MCLK), .reset(reset),
		.cpu_as_n(cpu_as_n), .cpu_uds_n(cpu_uds_n), .cpu_lds_n(cpu_lds_n),
		.cpu_rnw(cpu_rnw), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
		.cpu_rdata(cpu_rdata), .cpu_dtack_n(cpu_dtack_n),
		.z80_mreq_n(z80_mreq_n), .z80_rd_n(z80_rd_n), .z80_wr_n(z80_wr_n),
		.z80_addr(z80_addr), .z80_wdata(z80_wdata), .z80_rdata(z80_rdata),
		.z80_wait_n(z80_wait_n), .z80_busrq_n(z80_busrq_n), .z80_reset_n(z80_reset_n),
		.rom_size(rom_size), .rom_addr(rom_addr), .rom_req(rom_req),
		.rom_ack(rom_ack), .rom_data(rom_data)
	);

	always #50 MCLK = ~MCLK;

	task automatic check_value(input string name, input mdata_t got, input mdata_t expv,
			input mdata_t mask);
		checks++;
		if ((got & mask) !== (expv & mask)) begin
			errors++;
			$display("[FAIL] %0t ns %s expected %h got %h", $time, name,
				expv & mask, got & mask);
		end
	endtask

	// Entered and left 5 ns after a rising edge
	task automatic cpu_cycle(input logic wr, input logic [23:0] addr, input mdata_t data,
			input logic [1:0] lanes, output mdata_t rdata);
		cpu_addr = addr[23:1];
		cpu_rnw = ~wr;
		cpu_wdata = data;
		cpu_uds_n = ~lanes[1];
		cpu_lds_n = ~lanes[0];
		cpu_as_n = 1'b0;
		@(posedge MCLK);
		#5;
		while (cpu_dtack_n) begin
			@(posedge MCLK);
			#5;
		end
		rdata = cpu_rdata;
		cpu_as_n = 1'b1;
		cpu_uds_n = 1'b1;
		cpu_lds_n = 1'b1;
		cpu_rnw = 1'b1;
		// DTACK has to clear before the next cycle
		while (!cpu_dtack_n) begin
			@(posedge MCLK);
			#5;
		end
	endtask

	task automatic z80_cycle(input logic wr, input logic [15:0] addr, input zdata_t data,
			output zdata_t rdata);
		z80_addr = addr;
		z80_wdata = data;
		z80_mreq_n = 1'b0;
		z80_rd_n = wr;
		z80_wr_n = ~wr;
		@(posedge MCLK);
		#5;
		while (!z80_wait_n) begin
			@(posedge MCLK);
			#5;
		end
		rdata = z80_rdata;
		z80_mreq_n = 1'b1;
		z80_rd_n = 1'b1;
		z80_wr_n = 1'b1;
		@(posedge MCLK);
		#5;
	endtask

	// Cartridge ROM answers a toggled request after 0 to 3 cycles
	initial begin
		rom_ack = 1'b0;
		rom_data = '0;
		forever begin
			@(posedge MCLK);
			#5;
			if (!reset && rom_req != rom_ack) begin
				repeat ($urandom % 4) @(posedge MCLK);
				#5;
				rom_data = rom_addr[15:0] ^ 16'hA5A5;
				rom_ack = rom_req;
			end
		end
	end

	initial begin
		wait (loaded);
		repeat (n_vec * 300 + 20) @(posedge MCLK);
		$display("Timeout, the fabric stopped answering before all vectors ran");
		$display("%0d checks, %0d errors", checks, errors);
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		mdata_t got;
		zdata_t zgot;
		logic [83:0] v;
		int seed;
		logic exp_busrq_n;
		logic exp_reset_n;
		seed = $urandom(59);
		MCLK = 1'b0;
		reset = 1'b1;
		cpu_as_n = 1'b1;
		cpu_uds_n = 1'b1;
		cpu_lds_n = 1'b1;
		cpu_rnw = 1'b1;
		cpu_addr = '0;
		cpu_wdata = '0;
		z80_mreq_n = 1'b1;
		z80_rd_n = 1'b1;
		z80_wr_n = 1'b1;
		z80_addr = '0;
		z80_wdata = '0;
		rom_size = 23'h100000;
		errors = 0;
		checks = 0;
		n_vec = 0;
		loaded = 1'b0;
		exp_busrq_n = 1'b1;
		exp_reset_n = 1'b0;

		// Unused entries keep an illegal master field and end the table
		for (int i = 0; i < MAX_VEC; i++)
			vec[i] = '1;
		$readmemh("bench/md_bus_stimulus.txt", vec);
		while (n_vec < MAX_VEC && vec[n_vec][83:80] <= 4'd1)
			n_vec++;
		if (n_vec == 0) begin
			errors++;
			$display("No vectors could be read from bench/md_bus_stimulus.txt");
		end
		loaded = 1'b1;

		repeat (2) @(posedge MCLK);
		#5;
		reset = 1'b0;

		// ----------------------------
		// State right after reset
		// ----------------------------
		check_value("cpu_dtack_n", {15'd0, cpu_dtack_n}, 16'd1, 16'd1);
		check_value("z80_wait_n", {15'd0, z80_wait_n}, 16'd1, 16'd1);
		check_value("z80_busrq_n", {15'd0, z80_busrq_n}, 16'd1, 16'd1);
		check_value("z80_reset_n", {15'd0, z80_reset_n}, 16'd0, 16'd1);
		check_value("rom_req", {15'd0, rom_req}, 16'd0, 16'd1);

		for (int k = 0; k < n_vec; k++) begin
			v = vec[k];
			repeat (1 + $urandom % 4) @(posedge MCLK);
			#5;
			if (v[83:80] == 4'd0) begin
				cpu_cycle(v[79:76] != 4'd0, v[75:52], v[51:36], v[33:32], got);
				if (v[79:76] == 4'd0)
					check_value("cpu_rdata", got, v[31:16], v[15:0]);
				// Control register bit 8 sits on the upper lane
				if (v[79:76] != 4'd0 && v[33]) begin
					if (v[75:52] == 24'hA11100)
						exp_busrq_n = ~v[44];
					else if (v[75:52] == 24'hA11200)
						exp_reset_n = v[44];
				end
			end else begin
				z80_cycle(v[79:76] != 4'd0, v[67:52], v[43:36], zgot);
				if (v[79:76] == 4'd0)
					check_value("z80_rdata", {8'h00, zgot}, v[31:16], v[15:0]);
			end
			check_value("z80_busrq_n", {15'd0, z80_busrq_n}, {15'd0, exp_busrq_n}, 16'd1);
			check_value("z80_reset_n", {15'd0, z80_reset_n}, {15'd0, exp_reset_n}, 16'd1);
		end

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== bench/md_bus_stimulus.txt ====
// Columns: master (0 main CPU, 1 sound CPU) _ op (0 read, 1 write) _ byte address
// _ write data _ lanes (2 upper, 1 lower) _ expected read data _ compare mask
// Work RAM byte lanes
0_1_E00000_1234_3_0000_0000
0_0_E00000_0000_3_1234_FFFF
0_1_E00000_55AB_1_0000_0000
0_0_E00000_0000_3_12AB_FFFF
0_1_E00000_CD77_2_0000_0000
0_0_E00000_0000_3_CDAB_FFFF
// Sound RAM before the bus is granted
0_0_A00010_0000_3_FFFF_FFFF
// Bus request, then sound CPU reset release
0_1_A11100_0100_3_0000_0000
0_0_A11100_0000_3_0100_0100
0_1_A11200_0100_3_0000_0000
0_0_A11200_0000_3_0100_0100
// Sound RAM with the bus granted, 2000 apart is a mirror
0_1_A00010_1122_3_0000_0000
0_0_A00010_0000_3_1111_FFFF
0_0_A02010_0000_3_1111_FFFF
0_1_A00040_6600_2_0000_0000
0_0_A00040_0000_3_6666_FFFF
// Bus released so the write is dropped, then granted again
0_1_A11100_0000_3_0000_0000
0_0_A11100_0000_3_0000_0100
0_1_A00040_9900_2_0000_0000
0_0_A00040_0000_3_FFFF_FFFF
0_1_A11100_0100_3_0000_0000
0_0_A00040_0000_3_6666_FFFF
// Cartridge ROM of 2 MB, data is word address XOR A5A5
0_0_001234_0000_3_ACBF_FFFF
0_0_1FFFFE_0000_3_5A5A_FFFF
0_0_200000_0000_3_0000_FFFF
0_0_9FFFFE_0000_3_0000_FFFF
// Sound CPU on its own bus
1_0_000010_0000_0_0011_00FF
1_1_000050_005A_0_0000_0000
1_0_002050_0000_0_005A_00FF
1_0_004000_0000_0_00FF_00FF
// Bank 1C0 puts work RAM behind 8000, one bit per write, LSB first
1_1_006000_0000_0_0000_0000
1_1_006000_0000_0_0000_0000
1_1_006000_0000_0_0000_0000
1_1_006000_0000_0_0000_0000
1_1_006000_0000_0_0000_0000
1_1_006000_0000_0_0000_0000
1_1_006000_0001_0_0000_0000
1_1_006000_0001_0_0000_0000
1_1_006000_0001_0_0000_0000
// Window reads, a write back into work RAM, and the unmapped 7F00 page
1_0_008000_0000_0_00CD_00FF
1_0_008001_0000_0_00AB_00FF
1_1_008002_0077_0_0000_0000
0_0_E00002_0000_3_7700_FF00
1_0_007F00_0000_0_00FF_00FF

// ==== src.f ====
common/md_bus_pkg.sv
src/open_bus_noise.sv
src/work_ram.sv
src/z80_bridge.sv
src/mbus/mbus_ctrl.sv
src/zbus/zbus_ctrl.sv
src/md_bus_top.sv
bench/md_bus_tb.sv

// ==== Bender.yml ====
package:
  name: md_bus

sources:
  - common/md_bus_pkg.sv
  - src/open_bus_noise.sv
  - src/work_ram.sv
  - src/z80_bridge.sv
  - src/mbus/mbus_ctrl.sv
  - src/zbus/zbus_ctrl.sv
  - src/md_bus_top.sv
  - target: test
    files:
      - bench/md_bus_tb.sv
